/* design/store_settings.svh */
// Store path settings
// Widths and queue depth shared by the store unit and its testbench

`ifndef STORE_SETTINGS_SVH
`define STORE_SETTINGS_SVH

// Data width in bits
`define STORE_XLEN 64
// Virtual address width
`define STORE_VLEN 39
// Physical address width
`define STORE_PLEN 56
// Issue transaction ID width
`define STORE_TRANS_ID_BITS 3
// Store queue entries, a power of two
`define STORE_QUEUE_DEPTH 4
// Page offset bits compared against the load unit
`define STORE_PAGE_OFFSET_BITS 12

`endif

/* design/store_pkg.sv */
// Store path package
// Operation encoding, request and queue entry structs, size helper

`default_nettype none

`include "store_settings.svh"

package store_pkg;

  // Byte enables cover one double-word
  localparam int unsigned BE_W = `STORE_XLEN / 8;

  // Store width as issued
  typedef enum logic [1:0] {
    SB = 2'd0,
    SH = 2'd1,
    SW = 2'd2,
    SD = 2'd3
  } st_op_e;

  // Request from issue
  typedef struct packed {
    st_op_e                           op;
    logic [`STORE_VLEN-1:0]           vaddr;
    logic [`STORE_XLEN-1:0]           data;
    logic [`STORE_TRANS_ID_BITS-1:0]  trans_id;
  } st_req_t;

  // Accepted store, aligned and waiting for its physical address
  typedef struct packed {
    logic [`STORE_XLEN-1:0]           data;
    logic [BE_W-1:0]                  be;
    logic [1:0]                       size;
    logic [`STORE_TRANS_ID_BITS-1:0]  trans_id;
  } st_pending_t;

  // One slot of the store queue
  typedef struct packed {
    logic [`STORE_PLEN-1:0]  paddr;
    logic [`STORE_XLEN-1:0]  data;
    logic [BE_W-1:0]         be;
    logic [1:0]              size;
  } st_entry_t;

  // Data cache write request
  typedef struct packed {
    logic                    valid;
    logic [`STORE_PLEN-1:0]  paddr;
    logic [`STORE_XLEN-1:0]  data;
    logic [BE_W-1:0]         be;
    logic [1:0]              size;
  } mem_req_t;

  // Log2 of the byte count
  function automatic logic [1:0] op_size(st_op_e op);
    case (op)
      SB:      return 2'd0;
      SH:      return 2'd1;
      SW:      return 2'd2;
      default: return 2'd3;
    endcase
  endfunction

endpackage

`default_nettype wire

/* design/store_ctrl.sv */
// Store controller
// Sequences translation, acceptance and the completion cycle toward issue,
// and tells the queue when to take the aligned store

`timescale 1ns/1ns
`default_nettype none

module store_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic flush_i,
  // Issue request pending
  input  logic valid_i,
  // Translation answers
  input  logic dtlb_hit_i,
  input  logic fault_i,
  // Queue has room, pending push included
  input  logic queue_ready_i,
  output logic pop_st_o,
  output logic translation_req_o,
  // Completion toward issue
  output logic valid_o,
  output logic ex_valid_o,
  // Write the completing store into the queue
  output logic push_o
);

  typedef enum logic [1:0] {
    IDLE,
    VALID_STORE,
    WAIT_TRANSLATION,
    WAIT_STORE_READY
  } state_e;

  state_e state_d, state_q;
  logic   accept_ok;

  // Everything in place to take the request this cycle
  assign accept_ok = dtlb_hit_i && queue_ready_i && !flush_i;

  // Fault only reported on the completion cycle
  assign ex_valid_o = valid_o && fault_i;

  always_comb begin : fsm_comb
    state_d           = state_q;
    translation_req_o = 1'b0;
    pop_st_o          = 1'b0;
    valid_o           = 1'b0;
    push_o            = 1'b0;

    // Completion cycle, paddr and fault now valid
    if (state_q == VALID_STORE) begin
      valid_o = 1'b1;
      push_o  = !fault_i && !flush_i;
    end

    case (state_q)
      IDLE, VALID_STORE: begin
        if (valid_i) begin
          translation_req_o = 1'b1;
          if (accept_ok) begin
            pop_st_o = 1'b1;
            state_d  = VALID_STORE;
          end else if (!dtlb_hit_i) begin
            state_d = WAIT_TRANSLATION;
          end else if (!queue_ready_i) begin
            state_d = WAIT_STORE_READY;
          end
        end else begin
          state_d = IDLE;
        end
      end

      // TLB miss, keep asking
      WAIT_TRANSLATION: begin
        translation_req_o = 1'b1;
        if (dtlb_hit_i) state_d = IDLE;
      end

      // Queue full, hold the request until space frees up
      WAIT_STORE_READY: begin
        translation_req_o = 1'b1;
        if (queue_ready_i && dtlb_hit_i) state_d = IDLE;
      end

      default: state_d = IDLE;
    endcase

    if (flush_i) state_d = IDLE;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------
  // A popped request always completes on the next cycle
  a_pop_then_complete: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pop_st_o |-> valid_i ##1 valid_o
  );

  // Queue writes only follow a pop and never land during a flush
  a_push_after_pop: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    push_o |-> ($past(pop_st_o) && !flush_i)
  );

endmodule

`default_nettype wire

/* design/store_align.sv */
// Store aligner
// Rotates store data to its byte lane, builds the byte enable and holds
// the result for the completion cycle

`timescale 1ns/1ns
`default_nettype none

`include "store_settings.svh"

module store_align (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  store_pkg::st_req_t     st_req_i,
  output store_pkg::st_pending_t pending_o
);

  logic [2:0]                    offset;
  logic [5:0]                    shamt;
  logic [2*`STORE_XLEN-1:0]      data_dbl;
  logic [1:0]                    size;
  logic [store_pkg::BE_W-1:0]    be_mask;
  store_pkg::st_pending_t        pending_d;

  // Byte offset inside the double-word
  assign offset = st_req_i.vaddr[2:0];
  assign shamt  = {offset, 3'b000};

  // Rotate left, upper half of the doubled word wraps the high bytes
  assign data_dbl = {st_req_i.data, st_req_i.data} << shamt;

  assign size = store_pkg::op_size(st_req_i.op);

  // Lanes covered by the access before the offset shift
  always_comb begin : size_mask
    case (size)
      2'd0:    be_mask = 8'h01;
      2'd1:    be_mask = 8'h03;
      2'd2:    be_mask = 8'h0f;
      default: be_mask = 8'hff;
    endcase
  end

  assign pending_d.data     = data_dbl[2*`STORE_XLEN-1:`STORE_XLEN];
  assign pending_d.be       = be_mask << offset;
  assign pending_d.size     = size;
  assign pending_d.trans_id = st_req_i.trans_id;

  // Captured every cycle, read by the queue on the completion cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_o <= '0;
    end else begin
      pending_o <= pending_d;
    end
  end

endmodule

`default_nettype wire

/* design/store_queue.sv */
// Store queue
// Ring of translated stores split into speculative and committed regions,
// drains committed stores in order to the data cache

`timescale 1ns/1ns
`default_nettype none

`include "store_settings.svh"

module store_queue (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // Drops speculative entries
  input  logic                               flush_i,
  // Write side, completion cycle of an accepted store
  input  logic                               push_i,
  input  store_pkg::st_pending_t             pending_i,
  input  logic [`STORE_PLEN-1:0]             paddr_i,
  output logic                               ready_o,
  // Commit oldest speculative entry
  input  logic                               commit_i,
  output logic                               commit_ready_o,
  // Data cache port
  output store_pkg::mem_req_t                mem_req_o,
  input  logic                               mem_gnt_i,
  // Load unit address check
  input  logic [`STORE_PAGE_OFFSET_BITS-1:0] page_offset_i,
  output logic                               page_offset_matches_o,
  output logic                               no_st_pending_o,
  output logic                               empty_o
);

  localparam int unsigned DEPTH  = `STORE_QUEUE_DEPTH;
  localparam int unsigned PTR_W  = $clog2(DEPTH);
  localparam int unsigned CNT_W  = $clog2(DEPTH + 1);
  localparam int unsigned PAGE_W = `STORE_PAGE_OFFSET_BITS;

  store_pkg::st_entry_t queue_q [DEPTH];

  // Drain: oldest committed, commit: oldest speculative, write: next free
  logic [PTR_W-1:0] drain_ptr_q, commit_ptr_q, write_ptr_q;
  logic [PTR_W-1:0] drain_ptr_d, commit_ptr_d, write_ptr_d;
  logic [CNT_W-1:0] commit_cnt_q, spec_cnt_q;
  logic [CNT_W-1:0] commit_cnt_d, spec_cnt_d;
  logic [CNT_W-1:0] occupancy;
  logic             gnt;

  assign occupancy = commit_cnt_q + spec_cnt_q;
  assign gnt       = mem_gnt_i && mem_req_o.valid;

  // Room must also cover the store completing this cycle
  assign ready_o         = (occupancy + CNT_W'(push_i)) < CNT_W'(DEPTH);
  assign commit_ready_o  = spec_cnt_q != '0;
  assign no_st_pending_o = commit_cnt_q == '0;
  assign empty_o         = occupancy == '0;

  // ------------------------------------------------------------------
  // Pointer and count update
  // ------------------------------------------------------------------
  always_comb begin : ptr_comb
    drain_ptr_d  = drain_ptr_q + PTR_W'(gnt);
    commit_ptr_d = commit_ptr_q + PTR_W'(commit_i);
    write_ptr_d  = write_ptr_q + PTR_W'(push_i);
    commit_cnt_d = commit_cnt_q + CNT_W'(commit_i) - CNT_W'(gnt);
    spec_cnt_d   = spec_cnt_q + CNT_W'(push_i) - CNT_W'(commit_i);
    // Flush rewinds the write pointer past the committed region
    if (flush_i) begin
      write_ptr_d = commit_ptr_d;
      spec_cnt_d  = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      drain_ptr_q  <= '0;
      commit_ptr_q <= '0;
      write_ptr_q  <= '0;
      commit_cnt_q <= '0;
      spec_cnt_q   <= '0;
    end else begin
      drain_ptr_q  <= drain_ptr_d;
      commit_ptr_q <= commit_ptr_d;
      write_ptr_q  <= write_ptr_d;
      commit_cnt_q <= commit_cnt_d;
      spec_cnt_q   <= spec_cnt_d;
    end
  end

  // Entry storage, aligned payload joined with its translation
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      queue_q[write_ptr_q].paddr <= paddr_i;
      queue_q[write_ptr_q].data  <= pending_i.data;
      queue_q[write_ptr_q].be    <= pending_i.be;
      queue_q[write_ptr_q].size  <= pending_i.size;
    end
  end

  // Head of the committed region, held until granted
  assign mem_req_o.valid = commit_cnt_q != '0;
  assign mem_req_o.paddr = queue_q[drain_ptr_q].paddr;
  assign mem_req_o.data  = queue_q[drain_ptr_q].data;
  assign mem_req_o.be    = queue_q[drain_ptr_q].be;
  assign mem_req_o.size  = queue_q[drain_ptr_q].size;

  // ------------------------------------------------------------------
  // Page offset compare
  // ------------------------------------------------------------------
  always_comb begin : offset_match
    logic [PTR_W-1:0] age;
    page_offset_matches_o = 1'b0;
    for (int unsigned i = 0; i < DEPTH; i++) begin
      // Distance from the oldest entry tells if the slot is live
      age = PTR_W'(i) - drain_ptr_q;
      if ((CNT_W'(age) < occupancy) &&
          (queue_q[i].paddr[PAGE_W-1:3] == page_offset_i[PAGE_W-1:3])) begin
        page_offset_matches_o = 1'b1;
      end
    end
  end

  // Controller must not accept past full
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    push_i |-> (occupancy < CNT_W'(DEPTH))
  );

  // Commit stream in step with queued stores
  a_commit_has_entry: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    commit_i |-> (spec_cnt_q != '0)
  );

  // Cache grants only an outstanding request
  a_gnt_with_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_gnt_i |-> mem_req_o.valid
  );

endmodule

`default_nettype wire

/* design/store_unit.sv */
// Store unit top
// Joins the store controller, the data aligner and the store queue

`timescale 1ns/1ns
`default_nettype none

`include "store_settings.svh"

module store_unit (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               flush_i,
  // Issue side
  input  logic                               valid_i,
  input  store_pkg::st_req_t                 st_req_i,
  output logic                               pop_st_o,
  output logic                               valid_o,
  output logic [`STORE_TRANS_ID_BITS-1:0]    trans_id_o,
  output logic                               ex_valid_o,
  // Translation
  output logic                               translation_req_o,
  output logic [`STORE_VLEN-1:0]             vaddr_o,
  input  logic                               dtlb_hit_i,
  input  logic [`STORE_PLEN-1:0]             paddr_i,
  input  logic                               fault_i,
  // Commit
  input  logic                               commit_i,
  output logic                               commit_ready_o,
  // Data cache
  output store_pkg::mem_req_t                mem_req_o,
  input  logic                               mem_gnt_i,
  // Load unit
  input  logic [`STORE_PAGE_OFFSET_BITS-1:0] page_offset_i,
  output logic                               page_offset_matches_o,
  output logic                               no_st_pending_o,
  output logic                               store_buffer_empty_o
);

  logic                   push;
  logic                   queue_ready;
  store_pkg::st_pending_t pending;

  assign vaddr_o = st_req_i.vaddr;
  // ID of the store captured in the pop cycle
  assign trans_id_o = pending.trans_id;

  store_ctrl u_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .flush_i           (flush_i),
    .valid_i           (valid_i),
    .dtlb_hit_i        (dtlb_hit_i),
    .fault_i           (fault_i),
    .queue_ready_i     (queue_ready),
    .pop_st_o          (pop_st_o),
    .translation_req_o (translation_req_o),
    .valid_o           (valid_o),
    .ex_valid_o        (ex_valid_o),
    .push_o            (push)
  );

  store_align u_align (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .st_req_i  (st_req_i),
    .pending_o (pending)
  );

  store_queue u_queue (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .push_i                (push),
    .pending_i             (pending),
    .paddr_i               (paddr_i),
    .ready_o               (queue_ready),
    .commit_i              (commit_i),
    .commit_ready_o        (commit_ready_o),
    .mem_req_o             (mem_req_o),
    .mem_gnt_i             (mem_gnt_i),
    .page_offset_i         (page_offset_i),
    .page_offset_matches_o (page_offset_matches_o),
    .no_st_pending_o       (no_st_pending_o),
    .empty_o               (store_buffer_empty_o)
  );

endmodule

`default_nettype wire

/* testbench/tb_store_unit.sv */
// Store unit testbench
// Random stores with TLB misses, faults, commits, flushes and cache
// back-pressure, checked cycle by cycle against a queue model

`timescale 1ns/1ns
`default_nettype none

`include "store_settings.svh"

module tb_store_unit;

  localparam int unsigned N_STORES   = 200;
  localparam int unsigned MAX_CYCLES = 40 * N_STORES;
  localparam int unsigned NUM_TESTS  = 6;

  logic                               clk_i = 1'b0;
  logic                               rst_ni;
  logic                               flush_i;
  logic                               valid_i;
  store_pkg::st_req_t                 st_req_i;
  logic                               dtlb_hit_i;
  logic [`STORE_PLEN-1:0]             paddr_i;
  logic                               fault_i;
  logic                               commit_i;
  logic                               mem_gnt_i;
  logic [`STORE_PAGE_OFFSET_BITS-1:0] page_offset_i;

  logic                               pop_st_o;
  logic                               valid_o;
  logic [`STORE_TRANS_ID_BITS-1:0]    trans_id_o;
  logic                               ex_valid_o;
  logic                               translation_req_o;
  logic [`STORE_VLEN-1:0]             vaddr_o;
  logic                               commit_ready_o;
  store_pkg::mem_req_t                mem_req_o;
  logic                               page_offset_matches_o;
  logic                               no_st_pending_o;
  logic                               store_buffer_empty_o;

  // Model state, popped requests and the two queue regions
  store_pkg::st_req_t   outstanding_q[$];
  store_pkg::st_entry_t spec_q[$];
  store_pkg::st_entry_t committed_q[$];
  int unsigned          err_cnt [1:NUM_TESTS];
  int unsigned          check_cnt = 0;
  int unsigned          cycle_cnt = 0;
  int unsigned          issued = 0;
  int unsigned          flushes = 0;
  logic                 req_live = 1'b0;

  // Inputs for the next cycle, picked at the falling edge
  store_pkg::st_req_t                 nxt_req;
  logic                               nxt_hit;
  logic                               nxt_fault;
  logic                               nxt_flush;
  logic                               nxt_commit;
  logic                               nxt_gnt;
  logic [`STORE_PLEN-1:0]             nxt_paddr;
  logic [`STORE_PAGE_OFFSET_BITS-1:0] nxt_page;

  always #10 clk_i = ~clk_i;

  store_unit u_dut (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .st_req_i              (st_req_i),
    .pop_st_o              (pop_st_o),
    .valid_o               (valid_o),
    .trans_id_o            (trans_id_o),
    .ex_valid_o            (ex_valid_o),
    .translation_req_o     (translation_req_o),
    .vaddr_o               (vaddr_o),
    .dtlb_hit_i            (dtlb_hit_i),
    .paddr_i               (paddr_i),
    .fault_i               (fault_i),
    .commit_i              (commit_i),
    .commit_ready_o        (commit_ready_o),
    .mem_req_o             (mem_req_o),
    .mem_gnt_i             (mem_gnt_i),
    .page_offset_i         (page_offset_i),
    .page_offset_matches_o (page_offset_matches_o),
    .no_st_pending_o       (no_st_pending_o),
    .store_buffer_empty_o  (store_buffer_empty_o)
  );

  // ------------------------------------------------------------------
  // Reference rules
  // ------------------------------------------------------------------
  // Random store, address naturally aligned to its width
  function automatic store_pkg::st_req_t make_req(int unsigned id);
    store_pkg::st_req_t req;
    logic [63:0]        rnd;
    rnd          = {$urandom(), $urandom()};
    req.op       = store_pkg::st_op_e'($urandom_range(0, 3));
    req.vaddr    = rnd[`STORE_VLEN-1:0];
    req.data     = {$urandom(), $urandom()};
    req.trans_id = `STORE_TRANS_ID_BITS'(id);
    case (req.op)
      store_pkg::SH: req.vaddr[0]   = 1'b0;
      store_pkg::SW: req.vaddr[1:0] = 2'b00;
      store_pkg::SD: req.vaddr[2:0] = 3'b000;
      default: ;
    endcase
    return req;
  endfunction

  // Queue entry expected for a store completing at paddr
  function automatic store_pkg::st_entry_t expected_entry(store_pkg::st_req_t req,
                                                          logic [`STORE_PLEN-1:0] paddr);
    store_pkg::st_entry_t ent;
    int unsigned          off;
    int unsigned          nbytes;
    off = req.vaddr[2:0];
    case (req.op)
      store_pkg::SB: nbytes = 1;
      store_pkg::SH: nbytes = 2;
      store_pkg::SW: nbytes = 4;
      default:       nbytes = 8;
    endcase
    ent.paddr = paddr;
    ent.be    = '0;
    ent.size  = 2'($clog2(nbytes));
    ent.data  = '0;
    for (int unsigned b = 0; b < 8; b++) begin
      // Byte b moves up by the offset, wrapping inside the double-word
      ent.data[((b + off) % 8) * 8 +: 8] = req.data[b * 8 +: 8];
      if (b < nbytes) ent.be[b + off] = 1'b1;
    end
    return ent;
  endfunction

  // Any queued store in the same double-word of the page
  function automatic logic model_match(logic [`STORE_PAGE_OFFSET_BITS-1:0] off);
    logic hit;
    hit = 1'b0;
    foreach (spec_q[i]) begin
      if (spec_q[i].paddr[11:3] == off[11:3]) hit = 1'b1;
    end
    foreach (committed_q[i]) begin
      if (committed_q[i].paddr[11:3] == off[11:3]) hit = 1'b1;
    end
    return hit;
  endfunction

  function automatic string test_name(int unsigned t);
    case (t)
      1:       return "completion";
      2:       return "drain data";
      3:       return "tlb miss";
      4:       return "fault and commit";
      5:       return "flush and empty";
      default: return "page offset";
    endcase
  endfunction

  // ------------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------------
  task automatic check_flag(int unsigned test, string what, logic got, logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt[test]++;
      $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_completion(logic [`STORE_TRANS_ID_BITS-1:0] exp_id, logic exp_fault);
    check_cnt++;
    if (trans_id_o !== exp_id || ex_valid_o !== exp_fault) begin
      err_cnt[1]++;
      $display("error at %0t ns: completion id %0d fault %b, expected id %0d fault %b",
               $time, trans_id_o, ex_valid_o, exp_id, exp_fault);
    end
  endtask

  task automatic check_vaddr(logic [`STORE_VLEN-1:0] exp_vaddr);
    check_cnt++;
    if (vaddr_o !== exp_vaddr) begin
      err_cnt[3]++;
      $display("error at %0t ns: translation vaddr %h, expected %h",
               $time, vaddr_o, exp_vaddr);
    end
  endtask

  task automatic check_mem(store_pkg::mem_req_t exp);
    check_cnt++;
    if (mem_req_o !== exp) begin
      err_cnt[2]++;
      $display("error at %0t ns: cache request paddr %h data %h be %h size %0d",
               $time, mem_req_o.paddr, mem_req_o.data, mem_req_o.be, mem_req_o.size);
      $display("  expected paddr %h data %h be %h size %0d",
               exp.paddr, exp.data, exp.be, exp.size);
    end
  endtask

  // One cycle of checks and model update, outputs sampled mid-cycle
  task automatic step_model();
    store_pkg::st_req_t   done_req;
    store_pkg::st_entry_t ent;
    store_pkg::mem_req_t  exp_mem;
    logic                 push_ent;
    logic [63:0]          rnd;
    push_ent = 1'b0;
    // Status flags follow the model contents at cycle start
    check_flag(4, "commit_ready_o", commit_ready_o, spec_q.size() != 0);
    check_flag(4, "mem_req_o.valid", mem_req_o.valid, committed_q.size() != 0);
    check_flag(5, "no_st_pending_o", no_st_pending_o, committed_q.size() == 0);
    check_flag(5, "store_buffer_empty_o", store_buffer_empty_o,
               spec_q.size() == 0 && committed_q.size() == 0);
    check_flag(6, "page_offset_matches_o", page_offset_matches_o, model_match(page_offset_i));
    if (committed_q.size() != 0) begin
      exp_mem.valid = 1'b1;
      exp_mem.paddr = committed_q[0].paddr;
      exp_mem.data  = committed_q[0].data;
      exp_mem.be    = committed_q[0].be;
      exp_mem.size  = committed_q[0].size;
      check_mem(exp_mem);
    end
    // TLB miss holds the request and blocks the pop
    if (valid_i) begin
      check_flag(3, "translation_req_o", translation_req_o, 1'b1);
      // Translation asked for the live request
      check_vaddr(nxt_req.vaddr);
    end
    if (!valid_i || !dtlb_hit_i || flush_i) check_flag(3, "pop_st_o", pop_st_o, 1'b0);
    // Completion one cycle after the pop
    if (outstanding_q.size() != 0) begin
      done_req = outstanding_q.pop_front();
      check_flag(1, "valid_o", valid_o, 1'b1);
      check_completion(done_req.trans_id, fault_i);
      if (!fault_i && !flush_i) begin
        ent      = expected_entry(done_req, paddr_i);
        push_ent = 1'b1;
      end
    end else begin
      check_flag(1, "valid_o", valid_o, 1'b0);
      check_flag(1, "ex_valid_o", ex_valid_o, 1'b0);
    end
    // Grant, commit, push, then flush
    if (mem_gnt_i && committed_q.size() != 0) committed_q.delete(0);
    if (commit_i && spec_q.size() != 0) committed_q.push_back(spec_q.pop_front());
    if (push_ent) spec_q.push_back(ent);
    if (flush_i) begin
      spec_q.delete();
      flushes++;
    end
    if (pop_st_o) begin
      outstanding_q.push_back(st_req_i);
      req_live = 1'b0;
    end
    // Next stimulus
    if (!req_live && issued < N_STORES && $urandom_range(0, 9) < 8) begin
      nxt_req  = make_req(issued);
      issued++;
      req_live = 1'b1;
    end
    nxt_hit    = $urandom_range(0, 9) < 7;
    nxt_fault  = $urandom_range(0, 9) == 0;
    nxt_flush  = $urandom_range(0, 49) == 0;
    nxt_commit = spec_q.size() != 0 && !nxt_flush && $urandom_range(0, 1) == 1;
    nxt_gnt    = committed_q.size() != 0 && $urandom_range(0, 9) < 4;
    rnd        = {$urandom(), $urandom()};
    nxt_paddr  = rnd[`STORE_PLEN-1:0];
    // Few distinct double-words so that offset compares hit often
    nxt_paddr[11:3] = 9'($urandom_range(0, 7));
    nxt_page        = {9'($urandom_range(0, 7)), 3'($urandom_range(0, 7))};
  endtask

  // ------------------------------------------------------------------
  // Run control
  // ------------------------------------------------------------------
  always @(posedge clk_i) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin : run
    int unsigned total_err;
    void'($urandom(58));
    total_err = 0;
    foreach (err_cnt[t]) err_cnt[t] = 0;
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    valid_i       = 1'b0;
    st_req_i      = '0;
    dtlb_hit_i    = 1'b0;
    paddr_i       = '0;
    fault_i       = 1'b0;
    commit_i      = 1'b0;
    mem_gnt_i     = 1'b0;
    page_offset_i = '0;
    nxt_req       = '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Run until every store is issued and the model has drained
    while (!(issued == N_STORES && !req_live && outstanding_q.size() == 0 &&
             spec_q.size() == 0 && committed_q.size() == 0)) begin
      @(negedge clk_i);
      step_model();
      @(posedge clk_i);
      valid_i       <= req_live;
      st_req_i      <= nxt_req;
      dtlb_hit_i    <= nxt_hit;
      fault_i       <= nxt_fault;
      flush_i       <= nxt_flush;
      commit_i      <= nxt_commit;
      mem_gnt_i     <= nxt_gnt;
      paddr_i       <= nxt_paddr;
      page_offset_i <= nxt_page;
    end
    // Idle cycle, empty flags must be up
    @(negedge clk_i);
    step_model();
    for (int unsigned t = 1; t <= NUM_TESTS; t++) begin
      $display("test %0d %s: %0d errors", t, test_name(t), err_cnt[t]);
      total_err += err_cnt[t];
    end
    $display("%0d stores, %0d flushes, %0d checks, %0d errors",
             issued, flushes, check_cnt, total_err);
    if (total_err == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+design
design/store_pkg.sv
design/store_ctrl.sv
design/store_align.sv
design/store_queue.sv
design/store_unit.sv
testbench/tb_store_unit.sv

/* Bender.yml */
package:
  name: store_unit

sources:
  - include_dirs:
      - design
    files:
      - design/store_pkg.sv
      - design/store_ctrl.sv
      - design/store_align.sv
      - design/store_queue.sv
      - design/store_unit.sv
      - target: test
        files:
          - testbench/tb_store_unit.sv
